//--- design/dma_consts.svh
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// ------------------------------
// bus widths
// ------------------------------
`define OBI_ADDR_WIDTH 32
`define OBI_DATA_WIDTH 32
`define OBI_ID_WIDTH 4

// value returned by the id register
`define DMA_MAGIC 32'h69434017

// ------------------------------
// register word indices, addr[3:2]
// ------------------------------
`define DMA_REG_ID 2'd0
`define DMA_REG_DATA 2'd1
`define DMA_REG_LEN 2'd2

// reads in flight before req is held off
`define DMA_MAX_OUTSTANDING 2
// first/last tag queue entries
`define DMA_TAG_DEPTH 3

`endif

//--- design/obi_pkg.sv
`include "dma_consts.svh"

package obi_pkg;

	// byte address
	typedef logic [`OBI_ADDR_WIDTH-1:0] obi_addr_t;

	// data word, little endian
	typedef logic [`OBI_DATA_WIDTH-1:0] obi_data_t;

	// transaction id, echoed in the response
	typedef logic [`OBI_ID_WIDTH-1:0] obi_id_t;

	// one bit per data byte
	typedef logic [`OBI_DATA_WIDTH/8-1:0] obi_be_t;

endpackage

//--- design/dma_pkg.sv
`include "dma_consts.svh"

package dma_pkg;

	// transfer length in bytes, as written to the len register
	typedef logic [`OBI_DATA_WIDTH-1:0] byte_len_t;

	// byte position inside a bus word
	typedef logic [$clog2(`OBI_DATA_WIDTH/8)-1:0] byte_ofs_t;

	// reads granted but not yet retired
	typedef logic [$clog2(`DMA_MAX_OUTSTANDING+1)-1:0] outstanding_t;

	// bit 1 first read, bit 0 last read
	typedef logic [1:0] tag_t;

	// ------------------------------
	// read request generator
	// ------------------------------
	typedef enum logic {
		ADDR_IDLE,
		ADDR_ISSUE
	} addr_state_e;

endpackage

//--- design/obi_if.sv
`timescale 1ns/1ps

// ------------------------------
// subordinate bus, register side
// ------------------------------
interface obi_sbr_if;
	import obi_pkg::*;

	// request channel
	logic      req;
	logic      we;
	obi_addr_t addr;
	obi_data_t wdata;
	obi_id_t   aid;
	// grant and response channel
	logic      gnt;
	logic      rvalid;
	obi_data_t rdata;
	obi_id_t   rid;

	modport reg_side (
		input  req, we, addr, wdata, aid,
		output gnt, rvalid, rdata, rid
	);

	modport top_side (
		output req, we, addr, wdata, aid,
		input  gnt, rvalid, rdata, rid
	);
endinterface

// ------------------------------
// manager bus, read only
// ------------------------------
interface obi_mgr_if;
	import obi_pkg::*;

	logic      req;
	obi_addr_t addr;
	logic      gnt;
	logic      rvalid;
	obi_data_t rdata;

	// request generator
	modport gen_side (output req, addr, input gnt);
	// tag queue push on grant, pop on response
	modport tag_side (input req, gnt, rvalid);
	// realigner takes the response data
	modport data_side (input rvalid, rdata);
	modport top_side (input req, addr, output gnt, rvalid, rdata);
endinterface

//--- design/dma_reg_block.sv
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_reg_block (
	input  logic               clk_i,
	input  logic               rst_ni,
	obi_sbr_if.reg_side        sbr,
	input  logic               dma_idle_i,
	output logic               start_o,
	output obi_pkg::obi_addr_t start_addr_o,
	output dma_pkg::byte_len_t len_o,
	input  logic               word_valid_i,
	input  obi_pkg::obi_data_t word_i
);
	import obi_pkg::*;
	import dma_pkg::*;

	logic       accept;
	logic [1:0] reg_idx;
	logic       rvalid_q;
	logic [1:0] ridx_q;
	obi_id_t    rid_q;
	byte_len_t  len_q;
	obi_data_t  data_q;

	// never stalls the bus
	assign sbr.gnt = 1'b1;
	assign accept  = sbr.req & sbr.gnt;
	// word registers, 4 byte stride
	assign reg_idx = sbr.addr[3:2];

	// ------------------------------
	// start command
	// ------------------------------
	// data write while idle kicks off a read
	assign start_o      = accept & sbr.we & (reg_idx == `DMA_REG_DATA) & dma_idle_i;
	assign start_addr_o = obi_addr_t'(sbr.wdata);
	assign len_o        = len_q;

	// control and stored registers
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			rvalid_q <= 1'b0;
			len_q    <= '0;
			data_q   <= '0;
		end else begin
			// one response per accepted request
			rvalid_q <= accept;
			if (accept && sbr.we && reg_idx == `DMA_REG_LEN) begin
				len_q <= byte_len_t'(sbr.wdata);
			end
			// keep latest stream word
			if (word_valid_i) begin
				data_q <= word_i;
			end
		end
	end

	// response fields held for the next cycle
	always_ff @(posedge clk_i) begin
		if (accept) begin
			ridx_q <= reg_idx;
			rid_q  <= sbr.aid;
		end
	end

	// ------------------------------
	// read response
	// ------------------------------
	always_comb begin
		case (ridx_q)
			`DMA_REG_ID:   sbr.rdata = `DMA_MAGIC;
			`DMA_REG_DATA: sbr.rdata = data_q;
			`DMA_REG_LEN:  sbr.rdata = obi_data_t'(len_q);
			default:       sbr.rdata = '0;
		endcase
	end

	assign sbr.rvalid = rvalid_q;
	assign sbr.rid    = rid_q;

	// accepted start takes the engine out of idle
	a_start_leaves_idle: assert property (
		@(posedge clk_i) disable iff (!rst_ni) start_o |=> !dma_idle_i
	) else $error("CHECK FAILED %0t dma_idle_i expected 0 actual 1", $time);

endmodule

//--- design/dma_addr_gen.sv
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_addr_gen (
	input  logic               clk_i,
	input  logic               rst_ni,
	obi_mgr_if.gen_side        mgr,
	input  logic               start_i,
	input  obi_pkg::obi_addr_t start_addr_i,
	input  dma_pkg::byte_len_t len_i,
	input  logic               skip_i,
	input  logic               word_valid_i,
	output logic               idle_o,
	output dma_pkg::byte_ofs_t start_ofs_o,
	output logic               first_o,
	output logic               last_o
);
	import obi_pkg::*;
	import dma_pkg::*;

	addr_state_e  state_q;
	obi_addr_t    addr_q;
	byte_len_t    cnt_q;
	byte_len_t    span;
	byte_ofs_t    ofs_q;
	logic         first_q;
	outstanding_t oust_q;
	logic         at_limit;
	logic         granted;
	logic         retired;
	logic         accept_start;

	assign granted  = mgr.req & mgr.gnt;
	// a read retires as a word or as a dropped head read
	assign retired  = word_valid_i | skip_i;
	assign at_limit = (oust_q == outstanding_t'(`DMA_MAX_OUTSTANDING));

	// idle once issuing is over and every read has retired
	assign idle_o       = (state_q == ADDR_IDLE) && (oust_q == '0);
	assign accept_start = start_i & idle_o;

	// remaining bytes counted from the word base
	assign span   = cnt_q + byte_len_t'(ofs_q);
	assign last_o = (span <= byte_len_t'(4));
	assign first_o = first_q;
	assign start_ofs_o = ofs_q;

	// ------------------------------
	// bus request
	// ------------------------------
	// throttle at the outstanding limit
	assign mgr.req  = (state_q == ADDR_ISSUE) & ~at_limit;
	assign mgr.addr = addr_q;

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			state_q <= ADDR_IDLE;
			first_q <= 1'b0;
			ofs_q   <= '0;
		end else begin
			case (state_q)
				ADDR_IDLE: begin
					if (accept_start) begin
						state_q <= ADDR_ISSUE;
						first_q <= 1'b1;
						ofs_q   <= byte_ofs_t'(start_addr_i[1:0]);
					end
				end
				ADDR_ISSUE: begin
					if (granted) begin
						first_q <= 1'b0;
						// final word of the transfer went out
						if (last_o) begin
							state_q <= ADDR_IDLE;
						end
					end
				end
				default: state_q <= ADDR_IDLE;
			endcase
		end
	end

	// word address and byte countdown
	always_ff @(posedge clk_i) begin
		if (accept_start) begin
			addr_q <= {start_addr_i[`OBI_ADDR_WIDTH-1:2], 2'b00};
			cnt_q  <= len_i;
		end else if (granted) begin
			addr_q <= addr_q + obi_addr_t'(4);
			cnt_q  <= cnt_q - byte_len_t'(4);
		end
	end

	// ------------------------------
	// outstanding reads
	// ------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			oust_q <= '0;
		end else if (granted && !retired) begin
			oust_q <= oust_q + outstanding_t'(1);
		end else if (!granted && retired) begin
			oust_q <= oust_q - outstanding_t'(1);
		end
	end

	// no word or skip while nothing is in flight
	a_no_retire_idle: assert property (
		@(posedge clk_i) disable iff (!rst_ni) idle_o |-> !retired
	) else $error("CHECK FAILED %0t retired expected 0 actual 1", $time);

	// realigner never retires more reads than were granted
	a_oust_limit: assert property (
		@(posedge clk_i) disable iff (!rst_ni)
		oust_q <= outstanding_t'(`DMA_MAX_OUTSTANDING)
	) else $error("CHECK FAILED %0t oust expected <= %0d actual %0d", $time,
		`DMA_MAX_OUTSTANDING, oust_q);

endmodule

//--- design/dma_tag_fifo.sv
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_tag_fifo (
	input  logic          clk_i,
	input  logic          rst_ni,
	obi_mgr_if.tag_side   mgr,
	input  logic          first_i,
	input  logic          last_i,
	output dma_pkg::tag_t tag_o
);
	import dma_pkg::*;

	localparam int unsigned Depth = `DMA_TAG_DEPTH;
	localparam int unsigned PtrW  = $clog2(Depth);
	localparam int unsigned CntW  = $clog2(Depth + 1);

	tag_t            mem_q [Depth];
	logic [PtrW-1:0] wr_ptr_q;
	logic [PtrW-1:0] rd_ptr_q;
	logic [CntW-1:0] count_q;
	logic            push;
	logic            pop;
	logic            full;
	logic            empty;

	// tag enters with the grant, leaves with the response
	assign push  = mgr.req & mgr.gnt;
	assign pop   = mgr.rvalid;
	assign full  = (count_q == CntW'(Depth));
	assign empty = (count_q == '0);
	assign tag_o = mem_q[rd_ptr_q];

	always_ff @(posedge clk_i) begin
		if (push) begin
			mem_q[wr_ptr_q] <= {first_i, last_i};
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
			end
			if (pop) begin
				rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
			end
			if (push && !pop) begin
				count_q <= count_q + CntW'(1);
			end else if (pop && !push) begin
				count_q <= count_q - CntW'(1);
			end
		end
	end

	// more grants in flight than the bus allows
	a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni) full |-> !push)
		else $error("CHECK FAILED %0t tag push expected 0 actual 1", $time);
	// response with no granted read
	a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni) empty |-> !pop)
		else $error("CHECK FAILED %0t mgr.rvalid expected 0 actual 1", $time);

endmodule

//--- design/dma_realign.sv
`timescale 1ns/1ps

module dma_realign (
	input  logic               clk_i,
	input  logic               rst_ni,
	obi_mgr_if.data_side       mgr,
	input  dma_pkg::tag_t      tag_i,
	input  dma_pkg::byte_ofs_t start_ofs_i,
	input  dma_pkg::byte_ofs_t len_low_i,
	output logic               skip_o,
	output logic               word_valid_o,
	output obi_pkg::obi_data_t word_o
);
	import obi_pkg::*;
	import dma_pkg::*;

	logic            load;
	logic            drop;
	logic            tail;
	logic [2:0]      tail_span;
	logic            word_last;
	obi_data_t       in_word;
	obi_data_t       sel_word;
	logic [6:0][7:0] win;
	logic [2:0][7:0] prev_q;
	obi_data_t       out_q;
	logic            out_last_q;
	logic            valid_q;
	logic            skip_q;
	logic            flush_q;
	obi_be_t         keep_be;

	// ------------------------------
	// input window
	// ------------------------------
	// flush cycle shifts in a zero word
	assign load    = mgr.rvalid | flush_q;
	assign in_word = mgr.rvalid ? mgr.rdata : '0;
	// new word on top of the upper three bytes of the previous one
	assign win     = {in_word, prev_q};

	// final bytes sit inside the last read, so one more word is needed after it
	assign tail_span = {1'b0, len_low_i} + {1'b0, start_ofs_i};
	assign tail = (start_ofs_i != 2'd0) && (len_low_i != 2'd0) && (tail_span <= 3'd4);

	// unaligned head read only feeds the shift window
	assign drop = mgr.rvalid & tag_i[1] & ~tag_i[0] & (start_ofs_i != 2'd0);

	// last read of a tail transfer is not the last output word
	assign word_last = flush_q | (mgr.rvalid & tag_i[0] & ~(tail & ~tag_i[1]));

	// offset select
	always_comb begin
		sel_word = win[6:3];
		if (mgr.rvalid && tag_i[1] && tag_i[0]) begin
			// single read, bytes from the new word only
			case (start_ofs_i)
				2'd1:    sel_word = {8'h00, win[6:4]};
				2'd2:    sel_word = {16'h0000, win[6:5]};
				2'd3:    sel_word = {24'h000000, win[6]};
				default: sel_word = win[6:3];
			endcase
		end else begin
			case (start_ofs_i)
				2'd1:    sel_word = win[3:0];
				2'd2:    sel_word = win[4:1];
				2'd3:    sel_word = win[5:2];
				default: sel_word = win[6:3];
			endcase
		end
	end

	// ------------------------------
	// pipeline registers
	// ------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			valid_q <= 1'b0;
			skip_q  <= 1'b0;
			flush_q <= 1'b0;
		end else begin
			valid_q <= load & ~drop;
			// a tail transfer retires its head read with the flush word
			skip_q  <= drop & ~tail;
			flush_q <= mgr.rvalid & tag_i[0] & ~tag_i[1] & tail;
		end
	end

	always_ff @(posedge clk_i) begin
		if (load) begin
			prev_q     <= win[6:4];
			out_q      <= sel_word;
			out_last_q <= word_last;
		end
	end

	// valid bytes of the last word
	always_comb begin
		case (len_low_i)
			2'd1:    keep_be = 4'b0001;
			2'd2:    keep_be = 4'b0011;
			2'd3:    keep_be = 4'b0111;
			default: keep_be = 4'b1111;
		endcase
	end

	// zero bytes past the end
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			word_o[8*i +: 8] = (out_last_q && !keep_be[i]) ? 8'h00 : out_q[8*i +: 8];
		end
	end

	assign word_valid_o = valid_q;
	assign skip_o       = skip_q;

endmodule

//--- design/ascon_dma_top.sv
`timescale 1ns/1ps

module ascon_dma_top (
	input  logic               clk_i,
	input  logic               rst_ni,
	// register bus
	input  logic               sbr_req_i,
	input  logic               sbr_we_i,
	input  obi_pkg::obi_addr_t sbr_addr_i,
	input  obi_pkg::obi_data_t sbr_wdata_i,
	input  obi_pkg::obi_id_t   sbr_aid_i,
	output logic               sbr_gnt_o,
	output logic               sbr_rvalid_o,
	output obi_pkg::obi_data_t sbr_rdata_o,
	output obi_pkg::obi_id_t   sbr_rid_o,
	// memory read bus
	output logic               mgr_req_o,
	output obi_pkg::obi_addr_t mgr_addr_o,
	input  logic               mgr_gnt_i,
	input  logic               mgr_rvalid_i,
	input  obi_pkg::obi_data_t mgr_rdata_i
);
	import obi_pkg::*;
	import dma_pkg::*;

	obi_sbr_if sbr ();
	obi_mgr_if mgr ();

	logic      start;
	obi_addr_t start_addr;
	byte_len_t len;
	logic      idle;
	byte_ofs_t start_ofs;
	logic      first;
	logic      last;
	tag_t      tag;
	logic      skip;
	logic      word_valid;
	obi_data_t word;

	// ------------------------------
	// port to interface mapping
	// ------------------------------
	assign sbr.req      = sbr_req_i;
	assign sbr.we       = sbr_we_i;
	assign sbr.addr     = sbr_addr_i;
	assign sbr.wdata    = sbr_wdata_i;
	assign sbr.aid      = sbr_aid_i;
	assign sbr_gnt_o    = sbr.gnt;
	assign sbr_rvalid_o = sbr.rvalid;
	assign sbr_rdata_o  = sbr.rdata;
	assign sbr_rid_o    = sbr.rid;

	assign mgr_req_o  = mgr.req;
	assign mgr_addr_o = mgr.addr;
	assign mgr.gnt    = mgr_gnt_i;
	assign mgr.rvalid = mgr_rvalid_i;
	assign mgr.rdata  = mgr_rdata_i;

	dma_reg_block u_reg_block (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.sbr          (sbr),
		.dma_idle_i   (idle),
		.start_o      (start),
		.start_addr_o (start_addr),
		.len_o        (len),
		.word_valid_i (word_valid),
		.word_i       (word)
	);

	dma_addr_gen u_addr_gen (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.mgr          (mgr),
		.start_i      (start),
		.start_addr_i (start_addr),
		.len_i        (len),
		.skip_i       (skip),
		.word_valid_i (word_valid),
		.idle_o       (idle),
		.start_ofs_o  (start_ofs),
		.first_o      (first),
		.last_o       (last)
	);

	// tags follow the reads in order
	dma_tag_fifo u_tag_fifo (
		.clk_i   (clk_i),
		.rst_ni  (rst_ni),
		.mgr     (mgr),
		.first_i (first),
		.last_i  (last),
		.tag_o   (tag)
	);

	dma_realign u_realign (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.mgr          (mgr),
		.tag_i        (tag),
		.start_ofs_i  (start_ofs),
		.len_low_i    (len[1:0]),
		.skip_o       (skip),
		.word_valid_o (word_valid),
		.word_o       (word)
	);

endmodule

//--- dv/obi_mem_model.sv
`timescale 1ns/1ps

module obi_mem_model (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               req_i,
	input  obi_pkg::obi_addr_t addr_i,
	output logic               gnt_o,
	output logic               rvalid_o,
	output obi_pkg::obi_data_t rdata_o
);
	import obi_pkg::*;

	// 256 bytes, byte address wraps
	logic [7:0]  mem [256];
	integer      seed;
	int unsigned cycle_cnt;
	int unsigned wait_cnt;
	int unsigned gnt_delay;
	int unsigned last_due;
	// pending answers in grant order
	int unsigned due_q [$];
	obi_data_t   data_q [$];

	// little endian word at an aligned address
	function automatic obi_data_t read_word(input obi_addr_t addr);
		obi_data_t word;
		for (int i = 0; i < 4; i++) begin
			word[8*i +: 8] = mem[{addr[7:2], 2'(i)}];
		end
		return word;
	endfunction

	initial begin
		seed      = 6;
		cycle_cnt = 0;
		wait_cnt  = 0;
		last_due  = 0;
		gnt_o     = 1'b0;
		rvalid_o  = 1'b0;
		rdata_o   = '0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 8'(i * 7 + 3);
		end
		gnt_delay = $unsigned($random(seed)) % 3;
	end

	// ------------------------------
	// bookkeeping at the rising edge
	// ------------------------------
	always @(posedge clk_i) begin
		int unsigned due;
		if (!rst_ni) begin
			cycle_cnt = 0;
			wait_cnt  = 0;
			last_due  = 0;
			due_q.delete();
			data_q.delete();
		end else begin
			cycle_cnt++;
			// head answer went out in the cycle just ended
			if (rvalid_o) begin
				void'(due_q.pop_front());
				void'(data_q.pop_front());
			end
			if (req_i && gnt_o) begin
				// 1 to 3 cycles after the grant cycle
				due = cycle_cnt + ($unsigned($random(seed)) % 3);
				// keep answers in order
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				due_q.push_back(due);
				data_q.push_back(read_word(addr_i));
				wait_cnt  = 0;
				gnt_delay = $unsigned($random(seed)) % 3;
			end else if (req_i) begin
				wait_cnt++;
			end
		end
	end

	// outputs move on the falling edge only
	always @(negedge clk_i) begin
		if (!rst_ni) begin
			gnt_o    = 1'b0;
			rvalid_o = 1'b0;
		end else begin
			gnt_o = req_i && (wait_cnt >= gnt_delay);
			if (due_q.size() > 0 && due_q[0] == cycle_cnt) begin
				rvalid_o = 1'b1;
				rdata_o  = data_q[0];
			end else begin
				rvalid_o = 1'b0;
			end
		end
	end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/1ps
`include "dma_consts.svh"

module tb_top;
	import obi_pkg::*;
	import dma_pkg::*;

	// ------------------------------
	// run length
	// ------------------------------
	localparam int wait_cycles     = 80;
	localparam int num_random      = 6;
	// aligned, three unaligned, random, busy restart
	localparam int num_transfers   = 1 + 3 + num_random + 1;
	// register accesses around each wait
	localparam int transfer_cycles = wait_cycles + 12;
	localparam int timeout_cycles  = 10 + num_transfers * transfer_cycles + 200;

	logic      clk;
	logic      rst_n;
	logic      sbr_req;
	logic      sbr_we;
	obi_addr_t sbr_addr;
	obi_data_t sbr_wdata;
	obi_id_t   sbr_aid;
	logic      sbr_gnt;
	logic      sbr_rvalid;
	obi_data_t sbr_rdata;
	obi_id_t   sbr_rid;
	logic      mgr_req;
	obi_addr_t mgr_addr;
	logic      mgr_gnt;
	logic      mgr_rvalid;
	obi_data_t mgr_rdata;

	integer    seed;
	obi_id_t   next_aid;
	int        errors = 0;
	int        tests_run = 0;
	int        tests_failed = 0;
	int        cycle_cnt = 0;
	// reads granted on the memory bus, not yet answered
	int        pending = 0;

	ascon_dma_top uut (
		.clk_i        (clk),
		.rst_ni       (rst_n),
		.sbr_req_i    (sbr_req),
		.sbr_we_i     (sbr_we),
		.sbr_addr_i   (sbr_addr),
		.sbr_wdata_i  (sbr_wdata),
		.sbr_aid_i    (sbr_aid),
		.sbr_gnt_o    (sbr_gnt),
		.sbr_rvalid_o (sbr_rvalid),
		.sbr_rdata_o  (sbr_rdata),
		.sbr_rid_o    (sbr_rid),
		.mgr_req_o    (mgr_req),
		.mgr_addr_o   (mgr_addr),
		.mgr_gnt_i    (mgr_gnt),
		.mgr_rvalid_i (mgr_rvalid),
		.mgr_rdata_i  (mgr_rdata)
	);

	obi_mem_model u_mem (
		.clk_i    (clk),
		.rst_ni   (rst_n),
		.req_i    (mgr_req),
		.addr_i   (mgr_addr),
		.gnt_o    (mgr_gnt),
		.rvalid_o (mgr_rvalid),
		.rdata_o  (mgr_rdata)
	);

	// 100 ns period
	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("run stopped by timeout after %0d cycles", cycle_cnt);
			$display("Test failures found");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			pending <= 0;
		end else begin
			pending <= pending + int'(mgr_req && mgr_gnt) - int'(mgr_rvalid);
		end
	end

	// ------------------------------
	// protocol checks
	// ------------------------------
	a_sbr_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
		sbr_req && sbr_gnt |=> sbr_rvalid)
	else begin
		$display("CHECK FAILED %0t sbr_rvalid_o expected 1 actual 0", $time);
		errors = errors + 1;
	end

	// request held until granted
	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mgr_req && !mgr_gnt |=> mgr_req)
	else begin
		$display("CHECK FAILED %0t mgr_req_o expected 1 actual 0", $time);
		errors = errors + 1;
	end

	a_pending_limit: assert property (@(posedge clk) disable iff (!rst_n) pending <= 2)
	else begin
		$display("CHECK FAILED %0t pending reads expected <= 2 actual %0d", $time, pending);
		errors = errors + 1;
	end

	a_rvalid_has_read: assert property (@(posedge clk) disable iff (!rst_n)
		mgr_rvalid |-> pending > 0)
	else begin
		$display("memory answered at %0t with no read pending", $time);
		errors = errors + 1;
	end

	// model byte at a byte address
	function automatic logic [7:0] mem_byte(input int unsigned addr);
		return 8'(addr * 7 + 3);
	endfunction

	// last stream word, bytes after the full words, upper bytes zero
	function automatic obi_data_t final_word(input obi_addr_t start, input byte_len_t len);
		int unsigned rem;
		int unsigned base;
		obi_data_t   word;
		rem  = (len % 4 == 0) ? 4 : len % 4;
		base = start + len - rem;
		word = '0;
		for (int unsigned i = 0; i < rem; i++) begin
			word[8*i +: 8] = mem_byte(base + i);
		end
		return word;
	endfunction

	task automatic check_value(input string name, input obi_data_t expected,
			input obi_data_t actual);
		assert (actual == expected)
		else begin
			$display("CHECK FAILED %0t %s expected %08h actual %08h", $time, name,
				expected, actual);
			errors = errors + 1;
		end
	endtask

	// one access on the register bus, waits for its response
	task automatic reg_access(input logic we, input logic [1:0] idx, input obi_data_t wdata,
			output obi_data_t rdata);
		obi_id_t aid;
		int      waited;
		aid      = next_aid;
		next_aid = next_aid + obi_id_t'(1);
		@(negedge clk);
		sbr_req   = 1'b1;
		sbr_we    = we;
		sbr_addr  = obi_addr_t'({idx, 2'b00});
		sbr_wdata = wdata;
		sbr_aid   = aid;
		// grant tied high, taken at the next edge
		@(negedge clk);
		check_value("sbr_gnt_o", obi_data_t'(1'b1), obi_data_t'(sbr_gnt));
		sbr_req = 1'b0;
		sbr_we  = 1'b0;
		waited  = 0;
		while (!sbr_rvalid && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		if (!sbr_rvalid) begin
			$display("register block gave no response by %0t", $time);
			errors = errors + 1;
		end
		rdata = sbr_rdata;
		check_value("sbr_rid_o", obi_data_t'(aid), obi_data_t'(sbr_rid));
	endtask

	task automatic reg_write(input logic [1:0] idx, input obi_data_t wdata);
		obi_data_t ignored;
		reg_access(1'b1, idx, wdata, ignored);
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s: pass", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: fail", tests_run, name);
		end
	endtask

	// program length, start, then read back the last word
	task automatic run_transfer(input string name, input obi_addr_t start,
			input byte_len_t len);
		obi_data_t rdata;
		int        errors_before;
		errors_before = errors;
		reg_write(`DMA_REG_LEN, obi_data_t'(len));
		reg_write(`DMA_REG_DATA, obi_data_t'(start));
		// no done flag at the ports
		repeat (wait_cycles) @(negedge clk);
		reg_access(1'b0, `DMA_REG_DATA, '0, rdata);
		check_value("sbr_rdata_o", final_word(start, len), rdata);
		report_test(name, errors_before);
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		obi_data_t   rdata;
		byte_len_t   len;
		int unsigned base;
		int unsigned ofs;
		int          errors_before;
		seed      = 6;
		clk       = 1'b0;
		rst_n     = 1'b0;
		sbr_req   = 1'b0;
		sbr_we    = 1'b0;
		sbr_addr  = '0;
		sbr_wdata = '0;
		sbr_aid   = '0;
		next_aid  = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// quiet buses, then the id word
		errors_before = errors;
		check_value("mgr_req_o", '0, obi_data_t'(mgr_req));
		check_value("sbr_rvalid_o", '0, obi_data_t'(sbr_rvalid));
		reg_access(1'b0, `DMA_REG_ID, '0, rdata);
		check_value("sbr_rdata_o", `DMA_MAGIC, rdata);
		report_test("reset and id read", errors_before);

		run_transfer("aligned 4 bytes", obi_addr_t'(32'h40), byte_len_t'(4));
		for (int o = 1; o < 4; o++) begin
			run_transfer($sformatf("unaligned 4 bytes offset %0d", o),
				obi_addr_t'(32'h60 + o), byte_len_t'(4));
		end

		// several words, random length and start
		for (int n = 0; n < num_random; n++) begin
			len  = byte_len_t'(5 + ($unsigned($random(seed)) % 12));
			base = 16 + 4 * ($unsigned($random(seed)) % 40);
			ofs  = $unsigned($random(seed)) % 4;
			run_transfer($sformatf("random len %0d addr %0h", len, base + ofs),
				obi_addr_t'(base + ofs), len);
		end

		// second start lands while the engine is busy
		errors_before = errors;
		reg_write(`DMA_REG_LEN, 32'd16);
		reg_write(`DMA_REG_DATA, 32'h81);
		reg_write(`DMA_REG_DATA, 32'ha2);
		repeat (wait_cycles) @(negedge clk);
		reg_access(1'b0, `DMA_REG_DATA, '0, rdata);
		check_value("sbr_rdata_o", final_word(32'h81, 16), rdata);
		report_test("start while busy", errors_before);

		$display("tests run %0d, tests failed %0d, failed checks %0d", tests_run,
			tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+design
design/obi_pkg.sv
design/dma_pkg.sv
design/obi_if.sv
design/dma_reg_block.sv
design/dma_addr_gen.sv
design/dma_tag_fifo.sv
design/dma_realign.sv
design/ascon_dma_top.sv
dv/obi_mem_model.sv
dv/tb_top.sv

//--- Makefile
# Verilator build of the read DMA testbench

.PHONY: all compile run clean

all: run

# build the simulator binary into obj_dir
compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_top

# the exit status is the result of the search for the pass line
run: compile
	./obj_dir/Vtb_top | tee /dev/stderr | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir
